/* design/node_pkg.sv */
// Node output package
// Message, lookup and mapping structures shared by the node output side,
// together with the store and link widths

package node_pkg;

    // ====================
    // Widths
    // ====================

    // Store address and word widths
    localparam int STORE_ADDR_W = 10;
    localparam int STORE_DATA_W = 32;

    // One mesh link flit, half a message
    localparam int FLIT_W = 16;

    // ====================
    // Message format
    // ====================

    // Only the signal command is produced by this node side
    typedef enum logic [1:0] {
        NODE_COMMAND_LOAD,
        NODE_COMMAND_LOOPBACK,
        NODE_COMMAND_SIGNAL,
        NODE_COMMAND_CONTROL
    } node_command_t;

    // Routing header, 10 bits
    typedef struct packed {
        logic [3:0]    row;
        logic [3:0]    column;
        node_command_t command;
    } node_header_t;

    // Signal message, padded out to one 32-bit word
    typedef struct packed {
        node_header_t header;
        logic [4:0]   index;
        logic         is_seq;
        logic         state;
        logic [14:0]  padding;
    } node_message_t;

    // ====================
    // Store entries
    // ====================

    // Per-output lookup, range of mapping entries
    typedef struct packed {
        logic                    active;
        logic [STORE_ADDR_W-1:0] start;
        logic [STORE_ADDR_W-1:0] stop;
    } output_lookup_t;

    // One target of an output
    typedef struct packed {
        logic [3:0] row;
        logic [3:0] column;
        logic [4:0] index;
        logic       is_seq;
    } output_mapping_t;

    // Struct widths as seen in the store and on the link
    localparam int MESSAGE_W = $bits(node_message_t);
    localparam int LOOKUP_W  = $bits(output_lookup_t);
    localparam int MAPPING_W = $bits(output_mapping_t);

endpackage : node_pkg

/* design/lowest_change_finder.sv */
// Lowest change finder
// Priority encoder giving the position of the lowest set bit, so that
// simultaneous output changes are served from bit 0 upward

`timescale 1ns/1ps

module lowest_change_finder #(
    parameter int WIDTH = 32
) (
    input  logic [WIDTH-1:0]         i_vector,
    output logic [$clog2(WIDTH)-1:0] o_index
);

    localparam int IDX_W = $clog2(WIDTH);

    // Scan from the top so the lowest set bit wins
    always_comb begin : comb_find
        o_index = '0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (i_vector[i]) begin
                o_index = IDX_W'(i);
            end
        end
    end

endmodule : lowest_change_finder

/* design/node_mapping_store.sv */
// Node mapping store
// Single-port-read RAM holding lookup and mapping entries, loaded through
// a separate write port, with a registered one-cycle read

`timescale 1ns/1ps

module node_mapping_store
    import node_pkg::*;
(
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    // Load port
    input  logic                    i_wr_en,
    input  logic [STORE_ADDR_W-1:0] i_wr_addr,
    input  logic [STORE_DATA_W-1:0] i_wr_data,
    // Read port
    input  logic                    i_rd_en,
    input  logic [STORE_ADDR_W-1:0] i_rd_addr,
    output logic [STORE_DATA_W-1:0] o_rd_data
);

    localparam int ENTRIES = 2 ** STORE_ADDR_W;

    // ====================
    // Storage
    // ====================

    logic [STORE_DATA_W-1:0] mem [ENTRIES];

    // Write port
    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // ====================
    // Read port
    // ====================

    // Data follows the address by one cycle
    // Held while no read is requested
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rd_data <= '0;
        end else if (i_rd_en) begin
            o_rd_data <= mem[i_rd_addr];
        end
    end

endmodule : node_mapping_store

/* design/node_output_control.sv */
// Node output control
// Detects changes on the core outputs, fetches the output's lookup entry,
// walks its mapping range and emits one signal message per mapping

`timescale 1ns/1ps

module node_output_control
    import node_pkg::*;
#(
    parameter int OUTPUTS = 32
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    output logic                    o_idle,
    // Core outputs
    input  logic [OUTPUTS-1:0]      i_core_outputs,
    // Store read port
    output logic [STORE_ADDR_W-1:0] o_ram_addr,
    output logic                    o_ram_rd_en,
    input  logic [STORE_DATA_W-1:0] i_ram_rd_data,
    // Message stream
    output node_message_t           o_msg_data,
    output logic                    o_msg_valid,
    input  logic                    i_msg_ready
);

    localparam int IDX_W = $clog2(OUTPUTS);

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        QUERY,
        SEND
    } fsm_t;

    fsm_t                    state_q, state_d;

    // Change detection
    logic [OUTPUTS-1:0]      outputs_last_q, outputs_last_d;
    logic [OUTPUTS-1:0]      output_xor;
    logic                    output_change;
    logic [IDX_W-1:0]        change_index;
    logic [IDX_W-1:0]        index_q;
    logic                    value_q, value_d;

    // Store walk
    output_lookup_t          lookup_entry;
    output_lookup_t          lookup_q;
    output_mapping_t         mapping;
    logic [STORE_ADDR_W-1:0] rd_addr_q, rd_addr_d;
    logic [STORE_ADDR_W-1:0] stop_addr;
    logic                    last_q, last_d;

    // Message generation
    logic                    msg_stall;
    logic                    msg_valid_q, msg_valid_d;
    node_message_t           msg_q, msg_next;

    // ====================
    // Change detection
    // ====================

    assign output_xor    = i_core_outputs ^ outputs_last_q;
    assign output_change = |output_xor;

    lowest_change_finder #(
        .WIDTH    (OUTPUTS)
    ) u_finder (
        .i_vector (output_xor),
        .o_index  (change_index)
    );

    // Toggle the held bit as its lookup goes out, and keep its new value
    always_comb begin : comb_held
        outputs_last_d = outputs_last_q;
        value_d        = value_q;
        if (state_q == LOOKUP && !msg_stall) begin
            outputs_last_d[index_q] = ~outputs_last_q[index_q];
            value_d                 = ~outputs_last_q[index_q];
        end
    end

    // Pending changes keep the node busy
    assign o_idle = (state_q == IDLE) && !output_change;

    // ====================
    // FSM
    // ====================

    always_comb begin : comb_fsm
        state_d = state_q;
        case (state_q)
            // Wait for any output to move
            IDLE: begin
                if (output_change) state_d = LOOKUP;
            end
            // Lookup read goes out once the last message has left
            LOOKUP: begin
                if (!msg_stall) state_d = QUERY;
            end
            // Inactive output, nothing to send
            QUERY: begin
                if (!lookup_entry.active) begin
                    state_d = output_change ? LOOKUP : IDLE;
                end else begin
                    state_d = SEND;
                end
            end
            // Stream mappings until the stop entry is consumed
            SEND: begin
                if (last_q && !msg_stall) begin
                    state_d = output_change ? LOOKUP : IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // ====================
    // Store interface
    // ====================

    assign lookup_entry = output_lookup_t'(i_ram_rd_data[LOOKUP_W-1:0]);
    assign mapping      = output_mapping_t'(i_ram_rd_data[MAPPING_W-1:0]);

    // Lookup entries sit at the bottom of the store
    always_comb begin : comb_rd_addr
        rd_addr_d = rd_addr_q;
        if (!msg_stall) begin
            case (state_q)
                LOOKUP:  rd_addr_d = STORE_ADDR_W'(index_q);
                QUERY:   rd_addr_d = lookup_entry.start;
                SEND:    rd_addr_d = rd_addr_q + 1'b1;
                default: rd_addr_d = rd_addr_q;
            endcase
        end
    end

    // Stop comes straight from the store while the lookup is captured
    assign stop_addr = (state_q == QUERY) ? lookup_entry.stop : lookup_q.stop;
    assign last_d    = (rd_addr_d == stop_addr);

    // No read advances while a message is stuck
    assign o_ram_rd_en = (state_q != IDLE) && !msg_stall;
    assign o_ram_addr  = rd_addr_d;

    // ====================
    // Message generation
    // ====================

    assign msg_stall   = msg_valid_q && !i_msg_ready;
    assign msg_valid_d = msg_stall || (state_q == SEND);

    always_comb begin : comb_msg
        msg_next                = '0;
        msg_next.header.row     = mapping.row;
        msg_next.header.column  = mapping.column;
        msg_next.header.command = NODE_COMMAND_SIGNAL;
        msg_next.index          = mapping.index;
        msg_next.is_seq         = mapping.is_seq;
        msg_next.state          = value_q;
    end

    assign o_msg_data  = msg_q;
    assign o_msg_valid = msg_valid_q;

    // ====================
    // Registers
    // ====================

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q        <= IDLE;
            outputs_last_q <= '0;
            index_q        <= '0;
            value_q        <= 1'b0;
            rd_addr_q      <= '0;
            last_q         <= 1'b0;
            msg_valid_q    <= 1'b0;
        end else begin
            state_q        <= state_d;
            outputs_last_q <= outputs_last_d;
            index_q        <= change_index;
            value_q        <= value_d;
            rd_addr_q      <= rd_addr_d;
            last_q         <= last_d;
            msg_valid_q    <= msg_valid_d;
        end
    end

    // Lookup range and outgoing message
    always_ff @(posedge i_clk) begin
        if (state_q == QUERY) lookup_q <= lookup_entry;
        if (!msg_stall) msg_q <= msg_next;
    end

endmodule : node_output_control

/* design/message_fifo.sv */
// Message FIFO
// Circular valid/ready buffer for any payload type, with read and write
// pointers and an occupancy count

`timescale 1ns/1ps

module message_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic     i_clk,
    input  logic     i_rst_n,
    // Write side
    input  payload_t i_data,
    input  logic     i_valid,
    output logic     o_ready,
    // Read side
    output payload_t o_data,
    output logic     o_valid,
    input  logic     i_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    // Full blocks writes, empty blocks reads
    assign o_ready = (count_q != CNT_W'(DEPTH));
    assign o_valid = (count_q != '0);
    assign o_data  = mem[rd_ptr_q];

    assign push = i_valid && o_ready;
    assign pop  = o_valid && i_ready;

    // Entry storage
    always_ff @(posedge i_clk) begin
        if (push) mem[wr_ptr_q] <= i_data;
    end

    // Pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop leave the count alone
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule : message_fifo

/* design/message_egress.sv */
// Message egress
// Sends each buffered 32-bit message as two flits on the mesh link,
// upper half first

`timescale 1ns/1ps

module message_egress
    import node_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst_n,
    // From the FIFO
    input  node_message_t     i_msg,
    input  logic              i_msg_valid,
    output logic              o_msg_ready,
    // Mesh link
    output logic [FLIT_W-1:0] o_link_flit,
    output logic              o_link_valid,
    input  logic              i_link_ready
);

    logic [MESSAGE_W-1:0] msg_q;
    logic                 full_q;
    // Low means the upper flit is next
    logic                 half_q;
    logic                 flit_take;
    logic                 msg_take;

    assign flit_take = full_q && i_link_ready;

    // Refill as the lower flit leaves, no bubble between messages
    assign o_msg_ready = !full_q || (half_q && i_link_ready);
    assign msg_take    = i_msg_valid && o_msg_ready;

    assign o_link_valid = full_q;
    assign o_link_flit  = half_q ? msg_q[FLIT_W-1:0] : msg_q[MESSAGE_W-1:FLIT_W];

    // ====================
    // Flit sequencing
    // ====================

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            full_q <= 1'b0;
            half_q <= 1'b0;
        end else if (msg_take) begin
            full_q <= 1'b1;
            half_q <= 1'b0;
        end else if (flit_take) begin
            // Register empties after the lower flit
            full_q <= !half_q;
            half_q <= !half_q;
        end
    end

    always_ff @(posedge i_clk) begin
        if (msg_take) msg_q <= i_msg;
    end

endmodule : message_egress

/* design/node_output_top.sv */
// Node output top level
// Store, output control, message FIFO and link egress of a mesh node

`timescale 1ns/1ps

module node_output_top
    import node_pkg::*;
#(
    parameter int OUTPUTS    = 32,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic [OUTPUTS-1:0]      i_core_outputs,
    // Store load port, used while idle
    input  logic                    i_store_wr_en,
    input  logic [STORE_ADDR_W-1:0] i_store_wr_addr,
    input  logic [STORE_DATA_W-1:0] i_store_wr_data,
    output logic                    o_idle,
    // Mesh link
    output logic [FLIT_W-1:0]       o_link_flit,
    output logic                    o_link_valid,
    input  logic                    i_link_ready
);

    logic [STORE_ADDR_W-1:0] ram_addr;
    logic                    ram_rd_en;
    logic [STORE_DATA_W-1:0] ram_rd_data;
    node_message_t           ctl_msg;
    logic                    ctl_valid;
    logic                    ctl_ready;
    node_message_t           buf_msg;
    logic                    buf_valid;
    logic                    buf_ready;

    node_mapping_store u_store (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_wr_en   (i_store_wr_en),
        .i_wr_addr (i_store_wr_addr),
        .i_wr_data (i_store_wr_data),
        .i_rd_en   (ram_rd_en),
        .i_rd_addr (ram_addr),
        .o_rd_data (ram_rd_data)
    );

    node_output_control #(
        .OUTPUTS        (OUTPUTS)
    ) u_control (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .o_idle         (o_idle),
        .i_core_outputs (i_core_outputs),
        .o_ram_addr     (ram_addr),
        .o_ram_rd_en    (ram_rd_en),
        .i_ram_rd_data  (ram_rd_data),
        .o_msg_data     (ctl_msg),
        .o_msg_valid    (ctl_valid),
        .i_msg_ready    (ctl_ready)
    );

    // Signal messages only, the FIFO itself stays generic
    message_fifo #(
        .payload_t (node_message_t),
        .DEPTH     (FIFO_DEPTH)
    ) u_fifo (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_data    (ctl_msg),
        .i_valid   (ctl_valid),
        .o_ready   (ctl_ready),
        .o_data    (buf_msg),
        .o_valid   (buf_valid),
        .i_ready   (buf_ready)
    );

    message_egress u_egress (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_msg        (buf_msg),
        .i_msg_valid  (buf_valid),
        .o_msg_ready  (buf_ready),
        .o_link_flit  (o_link_flit),
        .o_link_valid (o_link_valid),
        .i_link_ready (i_link_ready)
    );

endmodule : node_output_top

/* bench/output_checker.sv */
// Link output checker
// Rebuilds messages from flit pairs, compares them in order with the
// expected messages and keeps per-test results

`timescale 1ns/1ps

module output_checker
    import node_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic [FLIT_W-1:0] i_link_flit,
    input  logic              i_link_valid,
    input  logic              i_link_ready,
    input  logic              i_idle
);

    logic [MESSAGE_W-1:0] expected_q [$];
    // Upper half waiting for its lower flit
    logic [FLIT_W-1:0]    upper_flit;
    logic                 have_upper;
    // Link state seen one cycle earlier
    logic [FLIT_W-1:0]    held_flit;
    logic                 held_stalled;
    int                   error_count;
    int                   errors_at_start;
    int                   tests_passed;
    int                   tests_failed;

    initial begin
        have_upper      = 1'b0;
        held_stalled    = 1'b0;
        error_count     = 0;
        errors_at_start = 0;
        tests_passed    = 0;
        tests_failed    = 0;
    end

    // ====================
    // Test bookkeeping
    // ====================

    task automatic report_failure(input string text);
        $display("ERROR at %0t: %s", $time, text);
        error_count++;
    endtask

    task automatic expect_message(input logic [MESSAGE_W-1:0] msg);
        expected_q.push_back(msg);
    endtask

    function automatic int pending_count();
        return expected_q.size();
    endfunction

    task automatic start_test();
        errors_at_start = error_count;
    endtask

    // Quiet link and idle node straight out of reset
    task automatic check_reset_state();
        if (i_link_valid !== 1'b0) begin
            $display("CHECK FAILED at %0t: link valid %b after reset, expected 0",
                     $time, i_link_valid);
            error_count++;
        end
        if (i_idle !== 1'b1) begin
            $display("CHECK FAILED at %0t: idle %b after reset, expected 1", $time, i_idle);
            error_count++;
        end
    endtask

    task automatic finish_test(input int test_num);
        if (have_upper) begin
            report_failure("test ended between the two flits of a message");
        end
        expected_q.delete();
        if (error_count == errors_at_start) begin
            tests_passed++;
            $display("test %0d passed", test_num);
        end else begin
            tests_failed++;
            $display("test %0d failed with %0d errors", test_num,
                     error_count - errors_at_start);
        end
    endtask

    task automatic print_summary();
        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
    endtask

    // ====================
    // Link monitor
    // ====================

    // Messages must arrive in the order they were expected
    task automatic check_message(input logic [MESSAGE_W-1:0] msg);
        logic [MESSAGE_W-1:0] expected;
        if (expected_q.size() == 0) begin
            report_failure($sformatf("message %h arrived with none expected", msg));
        end else begin
            expected = expected_q.pop_front();
            if (msg !== expected) begin
                $display("CHECK FAILED at %0t: message %h, expected %h", $time, msg, expected);
                error_count++;
            end
        end
    endtask

    // Sampled mid-cycle, transfer lands on the next rising edge
    always @(negedge i_clk) begin
        if (!i_rst_n) begin
            have_upper   = 1'b0;
            held_stalled = 1'b0;
        end else begin
            if ($isunknown(i_link_valid)) begin
                report_failure("link valid is unknown");
            end
            // A refused flit stays on the link unchanged
            if (held_stalled && (i_link_valid !== 1'b1 || i_link_flit !== held_flit)) begin
                report_failure("link flit was withdrawn or changed while stalled");
            end
            if (i_link_valid && i_link_ready) begin
                if (!have_upper) begin
                    upper_flit = i_link_flit;
                    have_upper = 1'b1;
                end else begin
                    check_message({upper_flit, i_link_flit});
                    have_upper = 1'b0;
                end
            end
            held_stalled = i_link_valid && !i_link_ready;
            held_flit    = i_link_flit;
        end
    end

endmodule : output_checker

/* bench/tb_node_outputs.sv */
// Node output testbench
// Loads the mapping store from the pattern file, steps the core outputs
// and lets the checker compare link traffic under random back-pressure

`timescale 1ns/1ps

module tb_node_outputs
    import node_pkg::*;
();

    localparam int OUTPUTS       = 32;
    // Single-entry FIFO lets message bursts back up into the control walk
    localparam int FIFO_DEPTH    = 1;
    // One record per data line of the pattern file
    localparam int PATTERN_DEPTH = 30;
    localparam int IDLE_TIMEOUT  = 200;
    localparam int DRAIN_TIMEOUT = 500;
    localparam int QUIET_CYCLES  = 4;

    localparam logic [3:0] KIND_STORE  = 4'h1;
    localparam logic [3:0] KIND_VECTOR = 4'h2;
    localparam logic [3:0] KIND_EXPECT = 4'h3;

    logic                    i_clk;
    logic                    i_rst_n;
    logic [OUTPUTS-1:0]      i_core_outputs;
    logic                    i_store_wr_en;
    logic [STORE_ADDR_W-1:0] i_store_wr_addr;
    logic [STORE_DATA_W-1:0] i_store_wr_data;
    logic                    o_idle;
    logic [FLIT_W-1:0]       o_link_flit;
    logic                    o_link_valid;
    logic                    i_link_ready;

    // Kind, test, address or ready level, data word
    logic [51:0]             patterns [PATTERN_DEPTH];
    integer                  seed;
    logic [2:0]              ready_level;
    logic                    timed_out;

    node_output_top #(
        .OUTPUTS         (OUTPUTS),
        .FIFO_DEPTH      (FIFO_DEPTH)
    ) UUT (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_core_outputs  (i_core_outputs),
        .i_store_wr_en   (i_store_wr_en),
        .i_store_wr_addr (i_store_wr_addr),
        .i_store_wr_data (i_store_wr_data),
        .o_idle          (o_idle),
        .o_link_flit     (o_link_flit),
        .o_link_valid    (o_link_valid),
        .i_link_ready    (i_link_ready)
    );

    output_checker u_checker (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_link_flit  (o_link_flit),
        .i_link_valid (o_link_valid),
        .i_link_ready (i_link_ready),
        .i_idle       (o_idle)
    );

    // ====================
    // Clock and link
    // ====================

    always begin
        #20 i_clk = ~i_clk;
    end

    // Ready with odds of ready_level out of 4
    always @(posedge i_clk) begin
        i_link_ready <= (($random(seed) & 3) < ready_level);
    end

    function automatic logic [3:0] record_kind(input logic [51:0] rec);
        return rec[51:48];
    endfunction

    function automatic logic [3:0] record_test(input logic [51:0] rec);
        return rec[47:44];
    endfunction

    // ====================
    // Sequencing
    // ====================

    task automatic load_store();
        int i;
        for (i = 0; i < PATTERN_DEPTH; i++) begin
            if (record_kind(patterns[i]) == KIND_STORE) begin
                @(posedge i_clk);
                i_store_wr_en   <= 1'b1;
                i_store_wr_addr <= patterns[i][41:32];
                i_store_wr_data <= patterns[i][31:0];
            end
        end
        @(posedge i_clk);
        i_store_wr_en <= 1'b0;
    endtask

    // First sample falls in the cycle of the new vector while the node is busy
    task automatic wait_for_idle();
        int cycles;
        cycles = 0;
        @(negedge i_clk);
        while (!o_idle && cycles < IDLE_TIMEOUT) begin
            @(negedge i_clk);
            cycles++;
        end
        if (!o_idle) begin
            u_checker.report_failure("node did not return to idle in time");
            timed_out = 1'b1;
        end
    endtask

    // Polled on the rising edge since the checker updates mid-cycle
    task automatic wait_for_messages();
        int cycles;
        cycles = 0;
        while (u_checker.pending_count() > 0 && cycles < DRAIN_TIMEOUT) begin
            @(posedge i_clk);
            cycles++;
        end
        if (u_checker.pending_count() > 0) begin
            u_checker.report_failure($sformatf("%0d expected messages never arrived",
                                               u_checker.pending_count()));
            timed_out = 1'b1;
        end
    endtask

    // Extra messages still in the FIFO show up before the link goes quiet
    task automatic wait_for_quiet_link();
        int cycles;
        int quiet;
        cycles = 0;
        quiet  = 0;
        while (quiet < QUIET_CYCLES && cycles < DRAIN_TIMEOUT) begin
            @(negedge i_clk);
            quiet = o_link_valid ? 0 : quiet + 1;
            cycles++;
        end
        if (quiet < QUIET_CYCLES) begin
            u_checker.report_failure("link kept sending after the last expected message");
            timed_out = 1'b1;
        end
    endtask

    task automatic run_test(input int rec);
        int         i;
        logic [3:0] test_num;
        test_num = record_test(patterns[rec]);
        for (i = 0; i < PATTERN_DEPTH; i++) begin
            if (record_kind(patterns[i]) == KIND_EXPECT &&
                record_test(patterns[i]) == test_num) begin
                u_checker.expect_message(patterns[i][31:0]);
            end
        end
        u_checker.start_test();
        @(posedge i_clk);
        ready_level    <= patterns[rec][34:32];
        i_core_outputs <= patterns[rec][OUTPUTS-1:0];
        wait_for_idle();
        if (!timed_out) wait_for_messages();
        if (!timed_out) wait_for_quiet_link();
        @(posedge i_clk);
        u_checker.finish_test(test_num);
    endtask

    initial begin : main
        int i;
        i_clk           = 1'b0;
        i_rst_n         = 1'b0;
        i_core_outputs  = '0;
        i_store_wr_en   = 1'b0;
        i_store_wr_addr = '0;
        i_store_wr_data = '0;
        i_link_ready    = 1'b0;
        seed            = 32'h54d65479;
        ready_level     = 3'd3;
        timed_out       = 1'b0;
        $readmemh("bench/node_outputs_patterns.txt", patterns);

        repeat (2) @(posedge i_clk);
        i_rst_n <= 1'b1;

        // Test 0 is the state right after reset
        u_checker.start_test();
        @(negedge i_clk);
        u_checker.check_reset_state();
        @(posedge i_clk);
        u_checker.finish_test(0);

        load_store();
        for (i = 0; i < PATTERN_DEPTH; i++) begin
            if (!timed_out && record_kind(patterns[i]) == KIND_VECTOR) begin
                run_test(i);
            end
        end

        @(posedge i_clk);
        u_checker.print_summary();
        if (!timed_out && u_checker.error_count == 0 && u_checker.tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule : tb_node_outputs

/* vlog.f */
design/node_pkg.sv
design/lowest_change_finder.sv
design/node_mapping_store.sv
design/node_output_control.sv
design/message_fifo.sv
design/message_egress.sv
design/node_output_top.sv
bench/output_checker.sv
bench/tb_node_outputs.sv

/* bench/node_outputs_patterns.txt */
// Fields are kind, test, store address or link ready level out of 4, data word
// Kind 1 loads a store word, kind 2 drives the outputs, kind 3 expects a message
// Lookup entries for outputs 0 to 5, output 1 inactive with a range left in
1_0_000_00108021
1_0_001_00008021
1_0_002_00108822
1_0_003_00108C24
1_0_005_00109427
// Mapping entries
1_0_020_00000486
1_0_021_00001163
1_0_022_00001C3E
1_0_023_00003FC1
1_0_024_00000A50
1_0_025_00000CCB
1_0_026_00002058
1_0_027_000003BD
// Output 0 rises, then falls
2_1_003_00000001
3_1_000_12868000
3_1_000_45A38000
2_2_002_00000000
3_2_000_12860000
3_2_000_45A30000
// Inactive output 1
2_3_003_00000002
// Outputs 0, 2 and 3 together
2_4_003_0000000F
3_4_000_12868000
3_4_000_45A38000
3_4_000_70BE8000
3_4_000_FF818000
3_4_000_29908000
// Output 5 under heavy back-pressure
2_5_001_0000002F
3_5_000_338B8000
3_5_000_81988000
3_5_000_0EBD8000
